// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_wormhole_router
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: noc_flit_if.sv
// one input port's FIFO head as seen by all five output arbiters
// grant is written by the top level as the OR of the arbiter grants

`timescale 1ns/100ps
`include "noc_settings.svh"

interface noc_flit_if;

  logic [`NOC_DIRS-1:0]   req;   // one-hot route of the head-of-line flit
  logic                   valid; // FIFO not empty
  logic [`NOC_FLIT_W-1:0] flit;
  logic                   last;  // closes the packet
  logic                   grant; // pop

  modport src
    (output req
    ,output valid
    ,output flit
    ,output last
    ,input  grant
    );

  // arbiters drive their own grant vector instead of this signal
  modport dst
    (input req
    ,input valid
    ,input flit
    ,input last
    );

endinterface

// File: noc_pkg.sv
// types shared by every router block
// head flit is {payload, len, target}, target in the low 6 bits
// direction order P,W,E,N,S is fixed here and nowhere else

`include "noc_settings.svh"

package noc_pkg;

  // port order, also the bit order of every one-hot route
  typedef enum logic [2:0] {
    P = 3'd0, // local processor
    W = 3'd1, // x lower
    E = 3'd2, // x higher
    N = 3'd3, // y lower
    S = 3'd4  // y higher
  } noc_dir_e;

  typedef enum logic {
    IDLE   = 1'b0, // waiting for a head flit
    LOCKED = 1'b1  // route held until the last flit
  } arb_state_e;

  typedef struct packed {
    logic [`NOC_CORD_W-1:0] y;
    logic [`NOC_CORD_W-1:0] x; // dim 0 in the low bits
  } noc_cord_s;

  typedef struct packed {
    logic [`NOC_FLIT_W-`NOC_LEN_W-2*`NOC_CORD_W-1:0] payload; // top 6 bits left to software
    logic [`NOC_LEN_W-1:0]                           len;     // body flits after the head
    noc_cord_s                                       target;
  } noc_head_s;

endpackage

// File: noc_settings.svh
// build-time sizes for the router node
// coordinates are fixed at 3+3 bits, the FIFO depth is the only real knob
// NOC_FIFO_DEPTH is also the credit count each sender starts with

`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// flit and head-flit field widths
`define NOC_FLIT_W      16
`define NOC_CORD_W      3
`define NOC_LEN_W       4

// input buffering, one credit per slot
`define NOC_FIFO_DEPTH  4

// counter wide enough to hold a full credit load
`define NOC_CREDIT_W    $clog2(`NOC_FIFO_DEPTH + 1)

// P, W, E, N, S
`define NOC_DIRS        5

`endif

// File: router_config.sv
// write-only node settings, reset to coordinate (0,0) and X-first
// addr 0 takes the coordinate from wdata[5:0], addr 1 the order bit from wdata[0]

`timescale 1ns/100ps
`include "noc_settings.svh"

module router_config
  (input  logic                   clk_i
  ,input  logic                   reset_i
  ,input  logic                   cfg_we_i
  ,input  logic [1:0]             cfg_addr_i
  ,input  logic [`NOC_FLIT_W-1:0] cfg_wdata_i
  ,output noc_pkg::noc_cord_s     my_cord_o
  ,output logic                   reverse_order_o
  );

  import noc_pkg::*;

  typedef enum logic [1:0] {
    cfg_cord_addr  = 2'd0,
    cfg_order_addr = 2'd1
  } cfg_addr_e;

  noc_cord_s my_cord_r;
  logic      reverse_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      my_cord_r <= '0;
      reverse_r <= 1'b0; // X then Y
    end
    else if (cfg_we_i)
    begin
      case (cfg_addr_e'(cfg_addr_i))
        cfg_cord_addr:  my_cord_r <= noc_cord_s'(cfg_wdata_i[2*`NOC_CORD_W-1:0]);
        cfg_order_addr: reverse_r <= cfg_wdata_i[0];
        default: ; // other addresses ignored
      endcase
    end
  end

  assign my_cord_o       = my_cord_r;
  assign reverse_order_o = reverse_r;

endmodule

// File: sim.f
+incdir+.
noc_pkg.sv
noc_flit_if.sv
wormhole_router_decoder_dor.sv
wormhole_input_port.sv
wormhole_output_arbiter.sv
router_config.sv
wormhole_router_top.sv
tb_wormhole_router.sv

// File: tb_wormhole_router.sv
// self-checking testbench for one router node under Verilator --timing
// flits carry their source in bits [15:13], so heads and bodies are traced per source
// output credits come back after 0 to 3 cycles unless an output is held

`timescale 1ns/100ps
`include "noc_settings.svh"

module tb_wormhole_router;

  import noc_pkg::*;

  localparam int dirs_lp  = `NOC_DIRS;
  localparam int depth_lp = `NOC_FIFO_DEPTH;
  localparam int pkts_lp  = 2 + 2 * 5 * 64 + 5 * 4 + 5 * 2; // all tests together
  localparam int watchdog_cycles_lp = pkts_lp * 4 * 40 + 1000; // 4 flits worst case

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic cfg_we = 1'b0;
  logic [1:0] cfg_addr = '0;
  logic [`NOC_FLIT_W-1:0] cfg_wdata = '0;
  logic [dirs_lp-1:0] link_valid_i = '0;
  logic [dirs_lp-1:0][`NOC_FLIT_W-1:0] link_data_i = '0;
  logic [dirs_lp-1:0] link_credit_o;
  logic [dirs_lp-1:0] link_valid_o;
  logic [dirs_lp-1:0][`NOC_FLIT_W-1:0] link_data_o;
  logic [dirs_lp-1:0] link_credit_i = '0;

  logic [`NOC_FLIT_W-1:0] snd_q [dirs_lp][$];         // flits waiting per input
  logic [`NOC_FLIT_W-1:0] exp_q [dirs_lp*dirs_lp][$]; // [out*5+src]
  int due_q [dirs_lp][$];                             // credit return cycles per output
  int cred [dirs_lp] = '{default: depth_lp};          // sender credits per input
  int outstanding [dirs_lp] = '{default: 0};
  int remain [dirs_lp] = '{default: 0};   // body flits left in the packet on an output
  int cur_src [dirs_lp] = '{default: 0};
  int out_cnt [dirs_lp] = '{default: 0};
  int seq [dirs_lp] = '{default: 0};
  bit hold [dirs_lp] = '{default: 1'b0};
  logic [31:0] lfsr_r = 32'h91d3;
  int cycle = 0;
  int errors = 0;
  int checked = 0;
  int n_tests = 0;
  int n_failed = 0;
  int my_x = 0;
  int my_y = 0;
  bit yfirst = 1'b0;

  wormhole_router_top i_dut
    (.clk_i         (clk)
    ,.reset_i       (reset)
    ,.cfg_we_i      (cfg_we)
    ,.cfg_addr_i    (cfg_addr)
    ,.cfg_wdata_i   (cfg_wdata)
    ,.link_valid_i  (link_valid_i)
    ,.link_data_i   (link_data_i)
    ,.link_credit_o (link_credit_o)
    ,.link_valid_o  (link_valid_o)
    ,.link_data_o   (link_data_o)
    ,.link_credit_i (link_credit_i)
    );

  always #20 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_r = lfsr_step(lfsr_r); // one step per bit
      v      = (v << 1) | int'(lfsr_r[0]);
    end
    return v;
  endfunction

  // dimension-ordered route where equal coordinates eject on P
  function automatic int ref_route(input int tx, input int ty, input int mx, input int my,
                                   input bit yf);
    if (tx == mx && ty == my)
      return int'(P);
    if (yf && ty != my)
      return (ty < my) ? int'(N) : int'(S);
    if (tx != mx)
      return (tx < mx) ? int'(W) : int'(E);
    return (ty < my) ? int'(N) : int'(S);
  endfunction

  function automatic bit all_idle();
    for (int d = 0; d < dirs_lp; d++)
      if (snd_q[d].size() != 0 || due_q[d].size() != 0 || cred[d] != depth_lp)
        return 1'b0;
    for (int k = 0; k < dirs_lp * dirs_lp; k++)
      if (exp_q[k].size() != 0)
        return 1'b0;
    return 1'b1;
  endfunction

  // queues a packet for the sender model and the scoreboard
  task automatic send_packet(input int src, input int tx, input int ty, input int len);
    logic [`NOC_FLIT_W-1:0] f;
    int out;
    out = ref_route(tx, ty, my_x, my_y, yfirst);
    f   = {3'(src), 3'(seq[src]), 4'(len), 3'(ty), 3'(tx)}; // head flit as {src, seq, len, y, x}
    snd_q[src].push_back(f);
    exp_q[out*dirs_lp+src].push_back(f);
    for (int i = 1; i <= len; i++)
    begin
      f = {3'(src), 3'(seq[src]), 4'(i), 6'(rand_bits(6))};
      snd_q[src].push_back(f);
      exp_q[out*dirs_lp+src].push_back(f);
    end
    seq[src] = seq[src] + 1;
  endtask

  task automatic write_cfg(input logic [1:0] addr, input logic [`NOC_FLIT_W-1:0] data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
    @(posedge clk); // stimulus is built on the rising side
  endtask

  task automatic drain();
    do
      @(posedge clk);
    while (!all_idle());
  endtask

  task automatic finish_test(input string name, input int errs_before);
    n_tests++;
    if (errors == errs_before)
      $display("test %s: passed", name);
    else
    begin
      n_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - errs_before);
    end
  endtask

  // sender models spend one credit per flit
  always @(negedge clk)
  begin
    for (int d = 0; d < dirs_lp; d++)
    begin
      link_valid_i[d] = 1'b0;
      if (!reset && link_credit_o[d])
      begin
        cred[d]++;
        if (cred[d] > depth_lp)
        begin
          $display("ERROR %0t: link_credit_o[%0d] returned more credits than flits sent",
                   $time, d);
          errors++;
        end
      end
      if (!reset && snd_q[d].size() > 0 && cred[d] > 0)
      begin
        link_valid_i[d] = 1'b1;
        link_data_i[d]  = snd_q[d].pop_front();
        cred[d]--;
      end
    end
  end

  // compare process and output credit models
  always @(negedge clk)
  begin
    logic [`NOC_FLIT_W-1:0] f;
    logic [`NOC_FLIT_W-1:0] want;
    int src;
    int key;
    cycle++;
    for (int o = 0; o < dirs_lp; o++)
    begin
      if (!reset && link_valid_o[o])
      begin
        f = link_data_o[o];
        out_cnt[o]++;
        outstanding[o]++;
        checked++;
        if (outstanding[o] > depth_lp)
        begin
          $display("ERROR %0t: output %0d sent a flit without a credit", $time, o);
          errors++;
        end
        due_q[o].push_back(cycle + rand_bits(2));
        src = (remain[o] == 0) ? int'(f[15:13]) : cur_src[o]; // bodies stay with the owner
        key = o * dirs_lp + src;
        if (src >= dirs_lp || exp_q[key].size() == 0)
        begin
          $display("ERROR %0t: unexpected flit %h on output %0d", $time, f, o);
          errors++;
        end
        else
        begin
          want = exp_q[key].pop_front();
          if (f !== want)
          begin
            $display("ERROR %0t: link_data_o[%0d] = %h, expected %h", $time, o, f, want);
            errors++;
          end
        end
        if (remain[o] == 0)
        begin
          cur_src[o] = src;
          remain[o]  = int'(f[9:6]);
        end
        else
          remain[o]--;
      end
      link_credit_i[o] = 1'b0;
      if (!hold[o] && due_q[o].size() > 0 && due_q[o][0] <= cycle)
      begin
        link_credit_i[o] = 1'b1;
        void'(due_q[o].pop_front());
        outstanding[o]--;
      end
    end
  end

  initial
  begin
    repeat (watchdog_cycles_lp) @(posedge clk);
    $display("watchdog expired after %0d cycles with flits still in flight",
             watchdog_cycles_lp);
    $display("Test failures found");
    $finish;
  end

  initial
  begin
    int e0;
    int base;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    // quiet links after reset then two short packets
    e0 = errors;
    repeat (10)
    begin
      @(negedge clk);
      if (|link_valid_o || |link_credit_o)
      begin
        $display("ERROR %0t: link activity after reset with no flit sent", $time);
        errors++;
      end
    end
    @(posedge clk);
    send_packet(int'(P), 0, 0, 2);
    send_packet(int'(W), 1, 1, 1); // reset order is X first so this leaves on E
    drain();
    finish_test("after reset", e0);

    e0 = errors;
    write_cfg(2'd0, {10'd0, 3'd2, 3'd2}); // node at (2,2)
    my_x = 2;
    my_y = 2;
    for (int t = 0; t < 64; t++)
      for (int s = 0; s < dirs_lp; s++)
        send_packet(s, t % 8, t / 8, rand_bits(2));
    drain();
    finish_test("x-first routing", e0);

    e0 = errors;
    write_cfg(2'd1, 16'd1);
    yfirst = 1'b1;
    for (int t = 0; t < 64; t++)
      for (int s = 0; s < dirs_lp; s++)
        send_packet(s, t % 8, t / 8, rand_bits(2));
    drain();
    finish_test("y-first routing", e0);

    // every input aims at W at once
    e0 = errors;
    write_cfg(2'd1, 16'd0);
    yfirst = 1'b0;
    for (int p = 0; p < 4; p++)
      for (int s = 0; s < dirs_lp; s++)
        send_packet(s, 0, 2, 3);
    drain();
    finish_test("contention", e0);

    e0   = errors;
    base = out_cnt[int'(E)];
    hold[int'(E)] = 1'b1;
    @(posedge clk);
    for (int p = 0; p < 2; p++)
      for (int s = 0; s < dirs_lp; s++)
        send_packet(s, 5, 2, 3);
    repeat (60) @(posedge clk);
    if (out_cnt[int'(E)] - base != depth_lp)
    begin
      $display("ERROR %0t: link_valid_o[%0d] count %0d while held, expected %0d",
               $time, int'(E), out_cnt[int'(E)] - base, depth_lp);
      errors++;
    end
    hold[int'(E)] = 1'b0;
    drain();
    finish_test("back-pressure", e0);

    $display("tests run %0d, failed %0d, flits checked %0d, errors %0d",
             n_tests, n_failed, checked, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: wormhole_input_port.sv
// credit-based input buffer, never full as long as the sender honours credits
// route and remaining body count are held from head pop to last pop

`timescale 1ns/100ps
`include "noc_settings.svh"

module wormhole_input_port
  (input  logic                   clk_i
  ,input  logic                   reset_i
  ,input  logic                   link_valid_i
  ,input  logic [`NOC_FLIT_W-1:0] link_data_i
  ,output logic                   link_credit_o
  ,input  noc_pkg::noc_cord_s     my_cord_i
  ,input  logic                   reverse_order_i
  ,noc_flit_if.src                out_if
  );

  import noc_pkg::*;

  localparam int depth_lp = `NOC_FIFO_DEPTH;
  localparam int ptr_w_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;
  localparam int cnt_w_lp = `NOC_CREDIT_W;

  logic [`NOC_FLIT_W-1:0] mem_r [depth_lp];
  logic [ptr_w_lp-1:0]    wptr_r;
  logic [ptr_w_lp-1:0]    rptr_r;
  logic [cnt_w_lp-1:0]    count_r;
  arb_state_e             state_r;  // LOCKED while a packet is in flight
  logic [`NOC_DIRS-1:0]   route_r;
  logic [`NOC_LEN_W-1:0]  remain_r; // body flits still to pop
  logic [`NOC_DIRS-1:0]   dec_req;
  noc_head_s              head;
  logic                   fifo_valid;
  logic                   pop;

  // wrap explicitly so non power-of-two depths work
  function automatic logic [ptr_w_lp-1:0] ptr_inc(input logic [ptr_w_lp-1:0] p);
    return (p == ptr_w_lp'(depth_lp - 1)) ? '0 : p + 1'b1;
  endfunction

  assign fifo_valid = (count_r != '0);
  assign head       = noc_head_s'(mem_r[rptr_r]); // only meaningful in IDLE
  assign pop        = fifo_valid & out_if.grant;

  wormhole_router_decoder_dor i_dec
    (.target_cord_i   (head.target)
    ,.my_cord_i       (my_cord_i)
    ,.reverse_order_i (reverse_order_i)
    ,.req_o           (dec_req)
    );

  always_ff @(posedge clk_i)
  begin
    if (link_valid_i)
      mem_r[wptr_r] <= link_data_i; // credits keep the sender from overrunning the FIFO
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r        <= '0;
      rptr_r        <= '0;
      count_r       <= '0;
      link_credit_o <= 1'b0;
    end
    else
    begin
      if (link_valid_i)
        wptr_r <= ptr_inc(wptr_r);
      if (pop)
        rptr_r <= ptr_inc(rptr_r);
      count_r       <= count_r + cnt_w_lp'(link_valid_i) - cnt_w_lp'(pop);
      link_credit_o <= pop; // one credit back per flit popped
    end
  end

  // packet tracking
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= IDLE;
    else if (pop)
    begin
      if (state_r == IDLE)
        state_r <= (head.len != '0) ? LOCKED : IDLE; // single-flit packet stays idle
      else if (remain_r == `NOC_LEN_W'(1))
        state_r <= IDLE;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (pop && state_r == IDLE)
    begin
      route_r  <= dec_req;
      remain_r <= head.len;
    end
    else if (pop)
      remain_r <= remain_r - 1'b1;
  end

  assign out_if.valid = fifo_valid;
  assign out_if.flit  = mem_r[rptr_r];
  assign out_if.req   = !fifo_valid ? '0 : (state_r == LOCKED) ? route_r : dec_req;
  assign out_if.last  = (state_r == LOCKED) ? (remain_r == `NOC_LEN_W'(1))
                                            : (head.len == '0);

endmodule

// File: wormhole_output_arbiter.sv
// one per output port, locks to a single input from head to last flit
// starts with NOC_FIFO_DEPTH credits, i.e. the downstream FIFO must match

`timescale 1ns/100ps
`include "noc_settings.svh"

module wormhole_output_arbiter
  #(parameter noc_pkg::noc_dir_e dir_p = noc_pkg::P)
  (input  logic                   clk_i
  ,input  logic                   reset_i
  ,noc_flit_if.dst                in_if [`NOC_DIRS]
  ,output logic [`NOC_DIRS-1:0]   grant_o
  ,output logic                   link_valid_o
  ,output logic [`NOC_FLIT_W-1:0] link_data_o
  ,input  logic                   link_credit_i
  );

  import noc_pkg::*;

  localparam int idx_w_lp    = $clog2(`NOC_DIRS);
  localparam int credit_w_lp = `NOC_CREDIT_W;

  logic [`NOC_DIRS-1:0]   req_v;  // inputs asking for this output
  logic [`NOC_DIRS-1:0]   last_v;
  logic [`NOC_FLIT_W-1:0] flit_v [`NOC_DIRS];
  arb_state_e             state_r;
  logic [idx_w_lp-1:0]    owner_r;
  logic [idx_w_lp-1:0]    ptr_r;  // highest priority next round
  logic [idx_w_lp-1:0]    winner;
  logic                   found;
  logic [credit_w_lp-1:0] credit_r;
  logic                   move;

  for (genvar i = 0; i < `NOC_DIRS; i++)
  begin : g_in
    assign req_v[i]  = in_if[i].valid & in_if[i].req[dir_p];
    assign last_v[i] = in_if[i].last;
    assign flit_v[i] = in_if[i].flit;
  end

  // round robin search starting at ptr_r
  always_comb
  begin
    int idx;
    winner = ptr_r;
    found  = 1'b0;
    for (int k = 0; k < `NOC_DIRS; k++)
    begin
      idx = (int'(ptr_r) + k) % `NOC_DIRS;
      if (!found && req_v[idx])
      begin
        winner = idx_w_lp'(idx);
        found  = 1'b1;
      end
    end
  end

  assign move = (state_r == LOCKED) & (credit_r != '0) & req_v[owner_r];

  always_comb
  begin
    grant_o          = '0;
    grant_o[owner_r] = move; // only the owner ever sees a grant
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r      <= IDLE;
      owner_r      <= '0;
      ptr_r        <= '0;
      credit_r     <= credit_w_lp'(`NOC_FIFO_DEPTH);
      link_valid_o <= 1'b0;
    end
    else
    begin
      link_valid_o <= move;
      credit_r     <= credit_r - credit_w_lp'(move) + credit_w_lp'(link_credit_i);
      case (state_r)
        IDLE:
          if (found)
          begin
            state_r <= LOCKED;
            owner_r <= winner;
            ptr_r   <= (winner == idx_w_lp'(`NOC_DIRS - 1)) ? '0 : winner + 1'b1; // skip past winner
          end
        LOCKED:
          if (move && last_v[owner_r])
            state_r <= IDLE; // release on the tail
        default:
          state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (move)
      link_data_o <= flit_v[owner_r];
  end

endmodule

// File: wormhole_router_decoder_dor.sv
// two-dimensional dimension-ordered route decode, purely combinational
// reverse_order_i = 0 routes X then Y, 1 routes Y then X

`timescale 1ns/100ps
`include "noc_settings.svh"

module wormhole_router_decoder_dor
  (input  noc_pkg::noc_cord_s   target_cord_i
  ,input  noc_pkg::noc_cord_s   my_cord_i
  ,input  logic                 reverse_order_i
  ,output logic [`NOC_DIRS-1:0] req_o
  );

  import noc_pkg::*;

  // bit 0 is x, bit 1 is y
  logic [1:0] eq;
  logic [1:0] lt;
  logic [1:0] gt;

  assign eq[0] = (target_cord_i.x == my_cord_i.x);
  assign lt[0] = (target_cord_i.x <  my_cord_i.x);
  assign gt[0] = ~eq[0] & ~lt[0];

  assign eq[1] = (target_cord_i.y == my_cord_i.y);
  assign lt[1] = (target_cord_i.y <  my_cord_i.y);
  assign gt[1] = ~eq[1] & ~lt[1];

  always_comb
  begin
    req_o    = '0;
    req_o[P] = &eq; // arrived, eject locally
    if (reverse_order_i)
    begin
      req_o[N] = lt[1];          // y resolved first
      req_o[S] = gt[1];
      req_o[W] = eq[1] & lt[0];  // then x
      req_o[E] = eq[1] & gt[0];
    end
    else
    begin
      req_o[W] = lt[0];          // x resolved first
      req_o[E] = gt[0];
      req_o[N] = eq[0] & lt[1];  // then y
      req_o[S] = eq[0] & gt[1];
    end
  end

endmodule

// File: wormhole_router_top.sv
// five-port wormhole router node, links indexed by noc_dir_e
// senders need a credit per flit and start with NOC_FIFO_DEPTH credits

`timescale 1ns/100ps
`include "noc_settings.svh"

module wormhole_router_top
  (input  logic                                  clk_i
  ,input  logic                                  reset_i
  ,input  logic                                  cfg_we_i
  ,input  logic [1:0]                            cfg_addr_i
  ,input  logic [`NOC_FLIT_W-1:0]                cfg_wdata_i
  ,input  logic [`NOC_DIRS-1:0]                  link_valid_i
  ,input  logic [`NOC_DIRS-1:0][`NOC_FLIT_W-1:0] link_data_i
  ,output logic [`NOC_DIRS-1:0]                  link_credit_o
  ,output logic [`NOC_DIRS-1:0]                  link_valid_o
  ,output logic [`NOC_DIRS-1:0][`NOC_FLIT_W-1:0] link_data_o
  ,input  logic [`NOC_DIRS-1:0]                  link_credit_i
  );

  import noc_pkg::*;

  noc_cord_s my_cord;
  logic      reverse_order;

  logic [`NOC_DIRS-1:0][`NOC_DIRS-1:0] grant_by_out; // [output][input]
  logic [`NOC_DIRS-1:0][`NOC_DIRS-1:0] grant_by_in;  // [input][output]

  noc_flit_if flit_if [`NOC_DIRS] ();

  router_config i_cfg
    (.clk_i           (clk_i)
    ,.reset_i         (reset_i)
    ,.cfg_we_i        (cfg_we_i)
    ,.cfg_addr_i      (cfg_addr_i)
    ,.cfg_wdata_i     (cfg_wdata_i)
    ,.my_cord_o       (my_cord)
    ,.reverse_order_o (reverse_order)
    );

  for (genvar d = 0; d < `NOC_DIRS; d++)
  begin : g_port
    wormhole_input_port i_in
      (.clk_i           (clk_i)
      ,.reset_i         (reset_i)
      ,.link_valid_i    (link_valid_i[d])
      ,.link_data_i     (link_data_i[d])
      ,.link_credit_o   (link_credit_o[d])
      ,.my_cord_i       (my_cord)
      ,.reverse_order_i (reverse_order)
      ,.out_if          (flit_if[d])
      );

    wormhole_output_arbiter #(.dir_p(noc_dir_e'(d))) i_arb
      (.clk_i         (clk_i)
      ,.reset_i       (reset_i)
      ,.in_if         (flit_if)
      ,.grant_o       (grant_by_out[d])
      ,.link_valid_o  (link_valid_o[d])
      ,.link_data_o   (link_data_o[d])
      ,.link_credit_i (link_credit_i[d])
      );

    // transpose, then at most one output grants a given input
    for (genvar o = 0; o < `NOC_DIRS; o++)
    begin : g_xpose
      assign grant_by_in[d][o] = grant_by_out[o][d];
    end

    assign flit_if[d].grant = |grant_by_in[d];
  end

endmodule
